//--- all.f
+incdir+dv
design/nandCmdPkg.sv
design/cmdAddrLatch.sv
design/beatTimer.sv
design/cmdSequencer.sv
design/nandPinDriver.sv
design/nandCmdAddrIssuer.sv
dv/tbNandCmdAddrIssuer.sv

//--- design/beatTimer.sv
`timescale 1ns/100ps

module beatTimer (
    input  logic                                    iSystemClock,
    input  logic                                    reset,
    input  logic                                    issueActive,
    input  logic [nandCmdPkg::byteCountWidth-1:0]   heldCount,
    output logic                                    byteAdvance,
    output logic                                    firstBeat,
    output logic                                    lastStep
);

    logic                                   started;      // turnaround cycle already seen
    logic                                   byteLive;
    logic                                   timeLast;
    logic [nandCmdPkg::beatCountWidth-1:0]  timeCount;
    logic [nandCmdPkg::byteCountWidth-1:0]  byteCount;

    // first active cycle belongs to the turnaround, bytes start after it
    assign byteLive = issueActive && started;
    assign timeLast = (timeCount ==
                       nandCmdPkg::beatCountWidth'(nandCmdPkg::cyclesPerByte - 1));

    assign firstBeat   = byteLive && (timeCount == '0);
    assign byteAdvance = byteLive && timeLast;

    always_ff @(posedge iSystemClock) begin
        if (reset) begin
            started   <= 1'b0;
            timeCount <= '0;
            byteCount <= '0;
            lastStep  <= 1'b0;
        end else begin
            started <= issueActive;

            // one clock early so it lines up with the registered pins
            lastStep <= byteAdvance && (byteCount == heldCount);

            if (!byteLive) begin
                timeCount <= '0;
                byteCount <= '0;
            end else if (timeLast) begin
                timeCount <= '0;
                byteCount <= byteCount + 1'b1;
            end else begin
                timeCount <= timeCount + 1'b1;
            end
        end
    end

endmodule

//--- design/cmdAddrLatch.sv
`timescale 1ns/100ps

module cmdAddrLatch (
    input  logic                                    iSystemClock,
    input  logic                                    reset,
    input  logic                                    capture,
    input  logic                                    byteAdvance,
    input  logic [nandCmdPkg::wayCount-1:0]         targetWay,
    input  logic [nandCmdPkg::byteCountWidth-1:0]   numBytes,
    input  logic                                    cmdSelect,
    input  logic [nandCmdPkg::caDataWidth-1:0]      caData,
    output logic [nandCmdPkg::byteWidth-1:0]        currentByte,
    output logic [nandCmdPkg::wayCount-1:0]         heldWay,
    output logic [nandCmdPkg::byteCountWidth-1:0]   heldCount,
    output logic                                    heldSelect
);

    logic [nandCmdPkg::caDataWidth-1:0]     shiftReg;
    logic [nandCmdPkg::byteCountWidth-1:0]  remaining;    // bytes still to shift past

    always_ff @(posedge iSystemClock) begin
        if (reset) begin
            heldCount <= '0;
            remaining <= '0;
        end else if (capture) begin
            heldCount <= numBytes;
            remaining <= numBytes;
        end else if (byteAdvance && remaining != '0) begin
            remaining <= remaining - 1'b1;
        end
    end

    // request payload
    always_ff @(posedge iSystemClock) begin
        if (capture) begin
            shiftReg   <= caData;
            heldWay    <= targetWay;
            heldSelect <= cmdSelect;
        end else if (byteAdvance) begin
            if (remaining == '0) begin
                // last byte done, leave the bus idle at zero
                shiftReg <= '0;
                heldWay  <= '0;
            end else begin
                shiftReg <= {shiftReg[nandCmdPkg::caDataWidth-nandCmdPkg::byteWidth-1:0],
                             {nandCmdPkg::byteWidth{1'b0}}};
            end
        end
    end

    assign currentByte = shiftReg[nandCmdPkg::caDataWidth-1 -: nandCmdPkg::byteWidth];

endmodule

//--- design/cmdSequencer.sv
`timescale 1ns/100ps

module cmdSequencer (
    input  logic    iSystemClock,
    input  logic    reset,
    input  logic    start,
    input  logic    lastStep,
    output logic    ready,
    output logic    capture,
    output logic    issueActive
);

    nandCmdPkg::sequencerState state;
    nandCmdPkg::sequencerState nextState;

    always_ff @(posedge iSystemClock) begin
        if (reset) begin
            state <= nandCmdPkg::stReset;
            ready <= 1'b0;
        end else begin
            state <= nextState;
            ready <= (nextState == nandCmdPkg::stReady);
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            nandCmdPkg::stReset: begin
                nextState = nandCmdPkg::stReady;
            end
            nandCmdPkg::stReady: begin
                if (start) begin
                    nextState = nandCmdPkg::stLatch;
                end
            end
            nandCmdPkg::stLatch: begin
                nextState = nandCmdPkg::stTurnaround;
            end
            nandCmdPkg::stTurnaround: begin
                nextState = nandCmdPkg::stIssue;
            end
            nandCmdPkg::stIssue: begin
                if (lastStep) begin
                    nextState = nandCmdPkg::stReady;
                end
            end
            default: begin
                nextState = nandCmdPkg::stReady;
            end
        endcase
    end

    assign capture = (state == nandCmdPkg::stReady) && start;    // start only counts here

    // Pins are registered downstream, so this runs one cycle ahead of the
    // state it describes. It drops in the lastStep cycle and the bus clears
    // together with ready rising.
    assign issueActive = (state == nandCmdPkg::stLatch)
                      || (state == nandCmdPkg::stTurnaround)
                      || ((state == nandCmdPkg::stIssue) && !lastStep);

endmodule

//--- design/nandCmdAddrIssuer.sv
`timescale 1ns/100ps

module nandCmdAddrIssuer (
    input  logic                                    iSystemClock,
    input  logic                                    reset,
    input  logic                                    start,
    input  logic [nandCmdPkg::wayCount-1:0]         targetWay,
    input  logic [nandCmdPkg::byteCountWidth-1:0]   numBytes,
    input  logic                                    cmdSelect,    // 1 command, 0 address
    input  logic [nandCmdPkg::caDataWidth-1:0]      caData,
    output logic                                    ready,
    output logic                                    lastStep,
    output logic [nandCmdPkg::wayCount-1:0]         chipEnable,
    output logic [nandCmdPkg::byteWidth-1:0]        dq,
    output logic                                    addressLatchEnable,
    output logic                                    commandLatchEnable
);

    logic                                   capture;
    logic                                   issueActive;
    logic                                   byteAdvance;
    logic                                   firstBeat;
    logic [nandCmdPkg::byteWidth-1:0]       currentByte;
    logic [nandCmdPkg::wayCount-1:0]        heldWay;
    logic [nandCmdPkg::byteCountWidth-1:0]  heldCount;
    logic                                   heldSelect;

    cmdSequencer sequencer (
        .iSystemClock   (iSystemClock),
        .reset          (reset),
        .start          (start),
        .lastStep       (lastStep),
        .ready          (ready),
        .capture        (capture),
        .issueActive    (issueActive)
    );

    cmdAddrLatch requestLatch (
        .iSystemClock   (iSystemClock),
        .reset          (reset),
        .capture        (capture),
        .byteAdvance    (byteAdvance),
        .targetWay      (targetWay),
        .numBytes       (numBytes),
        .cmdSelect      (cmdSelect),
        .caData         (caData),
        .currentByte    (currentByte),
        .heldWay        (heldWay),
        .heldCount      (heldCount),
        .heldSelect     (heldSelect)
    );

    beatTimer timer (
        .iSystemClock   (iSystemClock),
        .reset          (reset),
        .issueActive    (issueActive),
        .heldCount      (heldCount),
        .byteAdvance    (byteAdvance),
        .firstBeat      (firstBeat),
        .lastStep       (lastStep)
    );

    nandPinDriver pinDriver (
        .iSystemClock       (iSystemClock),
        .reset              (reset),
        .issueActive        (issueActive),
        .firstBeat          (firstBeat),
        .currentByte        (currentByte),
        .heldWay            (heldWay),
        .heldSelect         (heldSelect),
        .chipEnable         (chipEnable),
        .dq                 (dq),
        .addressLatchEnable (addressLatchEnable),
        .commandLatchEnable (commandLatchEnable)
    );

endmodule

//--- design/nandCmdPkg.sv
package nandCmdPkg;

    // channel geometry
    localparam int wayCount = 4;
    localparam int byteWidth = 8;    // flash data bus
    localparam int maxBytes = 5;

    // full command/address word with the top byte sent first
    localparam int caDataWidth = maxBytes * byteWidth;

    // numBytes holds count minus one
    localparam int byteCountWidth = 3;

    // clocks each byte stays on the bus
    localparam int cyclesPerByte = 3;
    localparam int beatCountWidth = $clog2(cyclesPerByte);

    typedef enum logic [2:0] {
        stReset,
        stReady,
        stLatch,
        stTurnaround,    // chip enable up, bus still quiet
        stIssue
    } sequencerState;

endpackage

//--- design/nandPinDriver.sv
`timescale 1ns/100ps

module nandPinDriver (
    input  logic                                iSystemClock,
    input  logic                                reset,
    input  logic                                issueActive,
    input  logic                                firstBeat,
    input  logic [nandCmdPkg::byteWidth-1:0]    currentByte,
    input  logic [nandCmdPkg::wayCount-1:0]     heldWay,
    input  logic                                heldSelect,
    output logic [nandCmdPkg::wayCount-1:0]     chipEnable,
    output logic [nandCmdPkg::byteWidth-1:0]    dq,
    output logic                                addressLatchEnable,
    output logic                                commandLatchEnable
);

    logic inBytes;     // past the first beat of byte 0
    logic byteLane;

    assign byteLane = issueActive && (firstBeat || inBytes);

    always_ff @(posedge iSystemClock) begin
        if (reset) begin
            inBytes            <= 1'b0;
            chipEnable         <= '0;
            dq                 <= '0;
            addressLatchEnable <= 1'b0;
            commandLatchEnable <= 1'b0;
        end else begin
            inBytes    <= byteLane;
            chipEnable <= issueActive ? heldWay : '0;    // held over the whole burst
            dq         <= byteLane ? currentByte : '0;

            // latch strobe only on the opening clock of each byte
            commandLatchEnable <= firstBeat && heldSelect;
            addressLatchEnable <= firstBeat && !heldSelect;
        end
    end

endmodule

//--- dv/tbIssuerTasks.svh
// per-clock record of one burst starting at the latch clock
logic [nandCmdPkg::byteWidth-1:0]   dqLog[$];
logic [nandCmdPkg::wayCount-1:0]    ceLog[$];
logic                               aleLog[$];
logic                               cleLog[$];
logic                               lastLog[$];
logic [nandCmdPkg::byteWidth-1:0]   idleDq;    // first clock with ready back up
logic [nandCmdPkg::wayCount-1:0]    idleCe;

task automatic reportMismatch(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
    $display("FAIL at time %0t: %s expected %0h, got %0h", $time, name, expected, actual);
    errorCount++;
    testErrors++;
endtask

task automatic finishTest(input string name);
    testCount++;
    if (testErrors == 0) begin
        $display("test %s: passed", name);
    end else begin
        $display("test %s: %0d errors", name, testErrors);
        failedTests++;
    end
    testErrors = 0;
endtask

task automatic waitReady();
    int waited;
    waited = 0;
    @(negedge iSystemClock);
    while (ready !== 1'b1 && waited < 50) begin
        @(negedge iSystemClock);
        waited++;
    end
    if (ready !== 1'b1) begin
        $display("ERROR at time %0t: ready stayed low for 50 clocks", $time);
        errorCount++;
        testErrors++;
    end
endtask

// starts one burst and records the pins until ready comes back
task automatic issueBurst(input logic [nandCmdPkg::wayCount-1:0] way,
                          input logic [nandCmdPkg::byteCountWidth-1:0] count,
                          input logic sel,
                          input logic [nandCmdPkg::caDataWidth-1:0] word,
                          input bit disturb);
    int cycle;
    cycle = 0;
    dqLog.delete();
    ceLog.delete();
    aleLog.delete();
    cleLog.delete();
    lastLog.delete();
    waitReady();
    if (ready !== 1'b1) return;
    start = 1'b1;
    targetWay = way;
    numBytes = count;
    cmdSelect = sel;
    caData = word;
    @(negedge iSystemClock);
    while (ready !== 1'b1 && cycle < 40) begin
        dqLog.push_back(dq);
        ceLog.push_back(chipEnable);
        aleLog.push_back(addressLatchEnable);
        cleLog.push_back(commandLatchEnable);
        lastLog.push_back(lastStep);
        cycle++;
        start = disturb && (cycle < 4);    // these starts land while busy
        if (disturb) begin
            targetWay = ~way;
            numBytes = ~count;
            cmdSelect = ~sel;
            caData = ~word;
        end
        @(negedge iSystemClock);
    end
    if (ready !== 1'b1) begin
        $display("ERROR at time %0t: burst still running after 40 clocks", $time);
        errorCount++;
        testErrors++;
    end
    idleDq = dq;
    idleCe = chipEnable;
endtask

task automatic checkBurst(input logic [nandCmdPkg::wayCount-1:0] way,
                          input logic [nandCmdPkg::byteCountWidth-1:0] count,
                          input logic sel,
                          input logic [nandCmdPkg::caDataWidth-1:0] word);
    int expectCycles;
    int beat;
    int i;
    string tag;
    logic [nandCmdPkg::byteWidth-1:0] expectDq;
    logic strobe;
    expectCycles = 2 + nandCmdPkg::cyclesPerByte * (int'(count) + 1);
    if (dqLog.size() != expectCycles)
        reportMismatch("clocks from start to ready", expectCycles, dqLog.size());
    for (i = 0; i < dqLog.size() && i < expectCycles; i++) begin
        tag = $sformatf(" clock %0d", i + 1);
        beat = i - 2;    // latch and turnaround come first
        expectDq = '0;
        strobe = 1'b0;
        if (beat >= 0) begin
            expectDq = word[nandCmdPkg::caDataWidth - 1 - nandCmdPkg::byteWidth * (beat / 3)
                            -: nandCmdPkg::byteWidth];
            strobe = (beat % 3 == 0);
        end
        if (i > 0 && ceLog[i] !== way) reportMismatch({"chipEnable", tag}, way, ceLog[i]);
        if (dqLog[i] !== expectDq) reportMismatch({"dq", tag}, expectDq, dqLog[i]);
        if (aleLog[i] !== (strobe && !sel))
            reportMismatch({"addressLatchEnable", tag}, strobe && !sel, aleLog[i]);
        if (cleLog[i] !== (strobe && sel))
            reportMismatch({"commandLatchEnable", tag}, strobe && sel, cleLog[i]);
        if (lastLog[i] !== (i == expectCycles - 1))
            reportMismatch({"lastStep", tag}, i == expectCycles - 1, lastLog[i]);
    end
    if (idleCe !== '0) reportMismatch("chipEnable after burst", 0, idleCe);
    if (idleDq !== '0) reportMismatch("dq after burst", 0, idleDq);
endtask

task automatic resetTest();
    repeat (5) begin
        @(negedge iSystemClock);
        if (ready !== 1'b0) reportMismatch("ready in reset", 0, ready);
        if (lastStep !== 1'b0) reportMismatch("lastStep in reset", 0, lastStep);
        if (chipEnable !== '0) reportMismatch("chipEnable in reset", 0, chipEnable);
        if (dq !== '0) reportMismatch("dq in reset", 0, dq);
        if ({addressLatchEnable, commandLatchEnable} !== 2'b00)
            reportMismatch("latch enables in reset", 0,
                           {addressLatchEnable, commandLatchEnable});
    end
    reset = 1'b0;
    waitReady();
    finishTest("reset");
endtask

task automatic addressBurstTest();
    issueBurst(4'b0101, 3'd4, 1'b0, 40'hA1B2C3D4E5, 1'b0);
    checkBurst(4'b0101, 3'd4, 1'b0, 40'hA1B2C3D4E5);
    finishTest("five-byte address burst");
endtask

task automatic commandBurstTest();
    int pulses;
    pulses = 0;
    issueBurst(4'b0010, 3'd0, 1'b1, 40'h90FFFFFFFF, 1'b0);
    checkBurst(4'b0010, 3'd0, 1'b1, 40'h90FFFFFFFF);
    foreach (cleLog[n]) pulses += int'(cleLog[n]);
    if (pulses != 1) reportMismatch("commandLatchEnable pulses", 1, pulses);
    finishTest("single-byte command burst");
endtask

task automatic lastStepTest();
    int pulses;
    pulses = 0;
    issueBurst(4'b1000, 3'd2, 1'b1, 40'h5A3C0F7700, 1'b0);
    checkBurst(4'b1000, 3'd2, 1'b1, 40'h5A3C0F7700);
    foreach (lastLog[n]) pulses += int'(lastLog[n]);
    if (pulses != 1) reportMismatch("lastStep pulses", 1, pulses);
    finishTest("lastStep");
endtask

task automatic isolationTest();
    issueBurst(4'b0110, 3'd3, 1'b0, 40'h13579BDF02, 1'b1);
    checkBurst(4'b0110, 3'd3, 1'b0, 40'h13579BDF02);
    finishTest("input isolation");
endtask

task automatic randomBurstTest();
    logic [nandCmdPkg::wayCount-1:0]        way;
    logic [nandCmdPkg::byteCountWidth-1:0]  count;
    logic                                   sel;
    logic [nandCmdPkg::caDataWidth-1:0]     word;
    repeat (20) begin
        way = nandCmdPkg::wayCount'($urandom);
        count = nandCmdPkg::byteCountWidth'($urandom % nandCmdPkg::maxBytes);
        sel = 1'($urandom);
        word = {8'($urandom), 32'($urandom)};
        issueBurst(way, count, sel, word, 1'b0);
        checkBurst(way, count, sel, word);
    end
    finishTest("random bursts");
endtask

//--- dv/tbNandCmdAddrIssuer.sv
`timescale 1ns/100ps

module tbNandCmdAddrIssuer;

    logic                                   iSystemClock;
    logic                                   reset;
    logic                                   start;
    logic [nandCmdPkg::wayCount-1:0]        targetWay;
    logic [nandCmdPkg::byteCountWidth-1:0]  numBytes;
    logic                                   cmdSelect;
    logic [nandCmdPkg::caDataWidth-1:0]     caData;
    logic                                   ready;
    logic                                   lastStep;
    logic [nandCmdPkg::wayCount-1:0]        chipEnable;
    logic [nandCmdPkg::byteWidth-1:0]       dq;
    logic                                   addressLatchEnable;
    logic                                   commandLatchEnable;

    int errorCount = 0;
    int testErrors = 0;     // errors in the running test
    int testCount = 0;
    int failedTests = 0;

    nandCmdAddrIssuer dut (
        .iSystemClock       (iSystemClock),
        .reset              (reset),
        .start              (start),
        .targetWay          (targetWay),
        .numBytes           (numBytes),
        .cmdSelect          (cmdSelect),
        .caData             (caData),
        .ready              (ready),
        .lastStep           (lastStep),
        .chipEnable         (chipEnable),
        .dq                 (dq),
        .addressLatchEnable (addressLatchEnable),
        .commandLatchEnable (commandLatchEnable)
    );

    always #50 iSystemClock = ~iSystemClock;

    `include "tbIssuerTasks.svh"

    initial begin
        iSystemClock = 1'b0;
        reset = 1'b1;
        start = 1'b0;
        targetWay = '0;
        numBytes = '0;
        cmdSelect = 1'b0;
        caData = '0;
        void'($urandom(29655));

        resetTest();
        addressBurstTest();
        commandBurstTest();
        lastStepTest();
        isolationTest();
        randomBurstTest();

        $display("summary: %0d tests, %0d failed, %0d errors", testCount, failedTests,
                 errorCount);
        if (errorCount == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- run.sh
#!/bin/sh
# build with Verilator, run, then look for the failure line in the log
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tbNandCmdAddrIssuer \
    -f all.f -o simNandIssuer > build.log 2>&1 \
    && ./obj_dir/simNandIssuer > sim.log 2>&1 \
    || { echo "build or simulation step failed, see build.log and sim.log"; exit 1; }
cat sim.log
! grep -q "Something failed" sim.log
